// ==== Makefile ====
SIM  := obj_dir/Vlease_cache_tb
SRCS := $(shell cat project.f)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): project.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module lease_cache_tb \
		-f project.f --Mdir obj_dir

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/backing_mem_model.sv ====
`timescale 1ns/1ps

module backing_mem_model import lease_cache_pkg::*; (
	input  logic                    clock_i,
	input  logic                    req_i,
	input  mem_req_t                mem_i,
	output logic                    ack_o,        // one cycle pulse
	output logic [31:0]             rdata_o,
	input  logic [BW_WORD_ADDR-1:0] peek_addr_i,  // bench view of contents
	output logic [31:0]             peek_data_o,
	output int unsigned             ack_count_o   // transactions since start
);

	localparam int DEPTH     = 1 << BW_WORD_ADDR;
	localparam int MAX_DELAY = 3;

	logic [31:0] mem [DEPTH];
	int          delay;

	// power-on contents, unique per address
	function automatic logic [31:0] fill_word(input logic [BW_WORD_ADDR-1:0] addr);
		return {addr ^ 16'hc3a5, addr};
	endfunction

	initial begin
		ack_o       = 1'b0;
		rdata_o     = '0;
		ack_count_o = 0;
		for (int a = 0; a < DEPTH; a++) begin
			mem[a] = fill_word(BW_WORD_ADDR'(a));
		end
		forever begin
			@(posedge clock_i);
			#1;                                   // request settled
			if (req_i) begin
				delay = $urandom_range(MAX_DELAY, 0);
				repeat (delay) begin
					@(posedge clock_i);
					#1;
				end
				if (mem_i.we) begin
					mem[mem_i.addr] = mem_i.wdata;
				end
				rdata_o = mem[mem_i.addr];
				ack_o   = 1'b1;
				ack_count_o++;
				@(posedge clock_i);
				#1;
				ack_o = 1'b0;
			end
		end
	end

	assign peek_data_o = mem[peek_addr_i];

endmodule

// ==== bench/lease_cache_tb.sv ====
`timescale 1ns/1ps

module lease_cache_tb import lease_cache_pkg::*; ();

	localparam int TIMEOUT = 200;             // cycles per wait

	logic                    clock, arst_n;
	logic                    core_req, core_done, core_hit;
	core_req_t               core;
	logic [31:0]             core_rdata;
	logic                    mem_req, mem_ack;
	mem_req_t                mem;
	logic [31:0]             mem_rdata;
	apb_req_t                apb;
	apb_rsp_t                apb_rsp;
	logic [BW_WORD_ADDR-1:0] peek_addr;
	logic [31:0]             peek_data;
	int unsigned             ack_count, txn_base;

	logic [31:0] shadow [1 << BW_WORD_ADDR];  // expected word per address
	string       test_name;
	logic        load_chk, hit_chk, byp_chk, apb_chk, apb_exp_err, peek_chk;
	logic [31:0] exp_rdata, apb_exp, peek_exp;
	int          errors, n_loads, n_apb;

	tb_clock_gen u_clk (.clock_o(clock), .arst_n_o(arst_n));

	backing_mem_model u_mem (
		.clock_i     (clock),
		.req_i       (mem_req),
		.mem_i       (mem),
		.ack_o       (mem_ack),
		.rdata_o     (mem_rdata),
		.peek_addr_i (peek_addr),
		.peek_data_o (peek_data),
		.ack_count_o (ack_count)
	);

	lease_cache_fa u_dut (
		.clock_i (clock), .arst_n_i (arst_n),
		.core_req_i (core_req), .core_i (core),
		.core_done_o (core_done), .core_hit_o (core_hit), .core_rdata_o (core_rdata),
		.mem_req_o (mem_req), .mem_o (mem), .mem_ack_i (mem_ack), .mem_rdata_i (mem_rdata),
		.apb_i (apb), .apb_o (apb_rsp)
	);

	// checks
	// --------------------------------------------------
	a_reset_quiet: assert property (@(posedge clock) $rose(arst_n) |-> !core_done && !mem_req)
		else begin
			errors++;
			$display("core_done_o or mem_req_o was high in the first cycle after reset");
		end

	a_load_data: assert property (@(posedge clock) disable iff (!arst_n)
		load_chk && core_done |-> core_rdata == exp_rdata)
		else begin
			errors++;
			$display("FAIL %s load %h: expected %h, actual %h", test_name,
				$sampled(core.addr), $sampled(exp_rdata), $sampled(core_rdata));
		end

	// req first seen two edges before done
	a_hit_timing: assert property (@(posedge clock) disable iff (!arst_n)
		hit_chk && core_done |-> core_hit && $past(core_req, 2) && !$past(core_req, 3))
		else begin
			errors++;
			$display("%s: repeated load did not hit with done two cycles after request",
				test_name);
		end

	a_bypass_txn: assert property (@(posedge clock) disable iff (!arst_n)
		byp_chk && core_done |-> ack_count - txn_base == 1)
		else begin
			errors++;
			$display("FAIL %s memory transactions: expected 1, actual %0d", test_name,
				$sampled(ack_count) - $sampled(txn_base));
		end

	a_bypass_miss: assert property (@(posedge clock) disable iff (!arst_n)
		byp_chk && core_done |-> !core_hit)
		else begin
			errors++;
			$display("%s: access with zero lease reported a hit", test_name);
		end

	a_apb_rdata: assert property (@(posedge clock) disable iff (!arst_n)
		apb_chk && apb.psel && apb.penable && !apb_exp_err |-> apb_rsp.prdata == apb_exp)
		else begin
			errors++;
			$display("FAIL %s apb read %h: expected %h, actual %h", test_name,
				$sampled(apb.paddr), $sampled(apb_exp), $sampled(apb_rsp.prdata));
		end

	a_apb_err: assert property (@(posedge clock) disable iff (!arst_n)
		apb.psel && apb.penable |-> apb_rsp.pslverr == apb_exp_err)
		else begin
			errors++;
			$display("FAIL %s pslverr at %h: expected %b, actual %b", test_name,
				$sampled(apb.paddr), $sampled(apb_exp_err), $sampled(apb_rsp.pslverr));
		end

	a_backing_word: assert property (@(posedge clock) peek_chk |-> peek_data == peek_exp)
		else begin
			errors++;
			$display("FAIL %s memory word %h: expected %h, actual %h", test_name,
				$sampled(peek_addr), $sampled(peek_exp), $sampled(peek_data));
		end

	// stimulus tasks
	// --------------------------------------------------
	function automatic logic [31:0] initial_word(input logic [BW_WORD_ADDR-1:0] addr);
		return {addr ^ 16'hc3a5, addr};          // backing memory power-on value
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("%0d loads, %0d register reads, %0d errors", n_loads, n_apb, errors);
		$display("SOME TESTS FAILED");
		$finish;
	endtask

	task automatic core_access(input logic rw, input logic [BW_WORD_ADDR-1:0] addr,
		input logic [31:0] wdata, input logic expect_hit, input logic expect_bypass);
		int t;
		@(posedge clock);
		#1;
		core_req  = 1'b1;
		core      = '{rw: rw, addr: addr, wdata: wdata};
		load_chk  = !rw;
		exp_rdata = shadow[addr];
		hit_chk   = expect_hit;
		byp_chk   = expect_bypass;
		txn_base  = ack_count;
		if (rw) begin
			shadow[addr] = wdata;
		end else begin
			n_loads++;
		end
		t = 0;
		while (!core_done && t < TIMEOUT) begin
			@(posedge clock);
			#1;
			t++;
		end
		if (!core_done) begin
			abort_run("core access timed out waiting for core_done_o");
		end else begin
			@(posedge clock);
			#1;                                     // held through the done cycle
			core_req = 1'b0;
			load_chk = 1'b0;
			hit_chk  = 1'b0;
			byp_chk  = 1'b0;
		end
	endtask

	task automatic apb_transfer(input logic write, input logic [BW_APB_ADDR-1:0] addr,
		input logic [31:0] wdata, input logic [31:0] exp, input logic exp_err);
		int t;
		@(posedge clock);
		#1;
		apb         = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
		apb_chk     = !write;
		apb_exp     = exp;
		apb_exp_err = exp_err;
		@(posedge clock);
		#1;
		apb.penable = 1'b1;                     // access phase
		t = 0;
		while (!apb_rsp.pready && t < TIMEOUT) begin
			@(posedge clock);
			#1;
			t++;
		end
		if (!apb_rsp.pready) begin
			abort_run("apb access timed out waiting for pready");
		end else begin
			@(posedge clock);
			#1;
			apb         = '0;
			apb_chk     = 1'b0;
			apb_exp_err = 1'b0;
			if (!write) n_apb++;
		end
	endtask

	task automatic apb_read(input logic [BW_APB_ADDR-1:0] addr, input logic [31:0] exp,
		input logic exp_err);
		apb_transfer(1'b0, addr, '0, exp, exp_err);
	endtask

	task automatic apb_write(input logic [BW_APB_ADDR-1:0] addr, input logic [31:0] data);
		apb_transfer(1'b1, addr, data, '0, 1'b0);
	endtask

	task automatic check_backing_word(input logic [BW_WORD_ADDR-1:0] addr);
		@(posedge clock);
		#1;
		peek_addr = addr;
		peek_exp  = shadow[addr];
		peek_chk  = 1'b1;
		@(posedge clock);
		#1;
		peek_chk = 1'b0;
	endtask

	// test sequence
	// --------------------------------------------------
	initial begin
		int                      t;
		logic [BW_WORD_ADDR-1:0] addr;
		logic                    rw;
		void'($urandom(32'hdd7));
		errors      = 0;
		n_loads     = 0;
		n_apb       = 0;
		core_req    = 1'b0;
		core        = '0;
		apb         = '0;
		peek_addr   = '0;
		txn_base    = 0;
		load_chk    = 1'b0;
		hit_chk     = 1'b0;
		byp_chk     = 1'b0;
		apb_chk     = 1'b0;
		peek_chk    = 1'b0;
		apb_exp_err = 1'b0;
		exp_rdata   = '0;
		apb_exp     = '0;
		peek_exp    = '0;
		for (int a = 0; a < (1 << BW_WORD_ADDR); a++) begin
			shadow[a] = initial_word(BW_WORD_ADDR'(a));
		end

		test_name = "reset";
		t = 0;
		while (!arst_n && t < TIMEOUT) begin
			@(posedge clock);
			t++;
		end
		if (!arst_n) begin
			abort_run("reset was never released");
		end else begin
			apb_read(REG_LEASE, 32'd4, 1'b0);
			apb_read(REG_HITS, '0, 1'b0);
			apb_read(REG_MISSES, '0, 1'b0);
			apb_read(REG_WBACKS, '0, 1'b0);
			apb_read(REG_FORCED, '0, 1'b0);

			// blocks 0..7 fill invalid slots, ninth finds block 0 expired and dirty
			test_name = "writeback";
			addr = '0;
			for (int k = 0; k < 9; k++) begin
				addr = 16'h0400 + BW_WORD_ADDR'(k * 4) + BW_WORD_ADDR'(k % 4);
				core_access(1'b1, addr, $urandom(), 1'b0, 1'b0);
			end
			apb_read(REG_MISSES, 32'd9, 1'b0);
			apb_read(REG_WBACKS, 32'd4, 1'b0);
			apb_read(REG_FORCED, '0, 1'b0);
			for (int w = 0; w < 4; w++) begin
				check_backing_word(16'h0400 + BW_WORD_ADDR'(w));
			end

			test_name = "hit";
			core_access(1'b0, addr, '0, 1'b1, 1'b0);   // same word as last store
			apb_read(REG_HITS, 32'd1, 1'b0);

			test_name = "apb";
			apb_write(REG_HITS, '0);                     // clears every counter
			apb_read(REG_HITS, '0, 1'b0);
			apb_read(REG_MISSES, '0, 1'b0);
			apb_read(REG_WBACKS, '0, 1'b0);
			apb_read(REG_FORCED, '0, 1'b0);
			apb_read(8'h20, '0, 1'b1);

			test_name = "random";
			for (int n = 0; n < 200; n++) begin
				addr = 16'h2000 + BW_WORD_ADDR'($urandom_range(63, 0)); // 16 blocks
				rw   = 1'($urandom_range(1, 0));
				core_access(rw, addr, $urandom(), 1'b0, 1'b0);
			end

			test_name = "bypass";
			apb_write(REG_LEASE, '0);
			apb_write(REG_HITS, '0);
			apb_read(REG_LEASE, '0, 1'b0);
			for (int n = 0; n < 4; n++) begin
				core_access(n % 2 == 0, 16'h7f01, $urandom(), 1'b0, 1'b1); // store, then load
				apb_read(REG_MISSES, 32'(n + 1), 1'b0);
			end

			@(posedge clock);
			#1;
			$display("%0d loads, %0d register reads, %0d errors", n_loads, n_apb, errors);
			if (errors == 0) begin
				$display("ALL TESTS PASSED");
			end else begin
				$display("SOME TESTS FAILED");
			end
			$finish;
		end
	end

endmodule

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clock_o,
	output logic arst_n_o
);

	localparam int RESET_CYCLES = 16;

	initial begin
		clock_o = 1'b0;
		forever #5 clock_o = ~clock_o;          // 10 ns period
	end

	initial begin
		arst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock_o);
		#1;
		arst_n_o = 1'b1;                        // release off the edge
	end

endmodule

// ==== design/cache_data_mem.sv ====
`timescale 1ns/1ps

module cache_data_mem import lease_cache_pkg::*; (
	input  logic                          clock_i,
	input  logic                          wren_i,
	input  logic [BW_CACHE_ADDR_FULL-1:0] addr_i,   // [block|word]
	input  logic [31:0]                   data_i,
	output logic [31:0]                   q_o       // registered, old data on write
);

	localparam int DEPTH = CACHE_BLOCK_CAPACITY << BW_BLOCK;

	logic [31:0] mem [DEPTH];

	always_ff @(posedge clock_i) begin
		if (wren_i) begin
			mem[addr_i] <= data_i;
		end
		q_o <= mem[addr_i];
	end

endmodule

// ==== design/cache_perf_regs.sv ====
`timescale 1ns/1ps

module cache_perf_regs import lease_cache_pkg::*; (
	input  logic                clock_i,
	input  logic                arst_n_i,
	input  perf_flags_t         flags_i,
	input  apb_req_t            apb_i,
	output apb_rsp_t            apb_o,
	output logic [BW_LEASE-1:0] lease_o     // default lease register
);

	logic [31:0] count_q [4];                // hits, misses, wbacks, forced
	logic [3:0]  events;
	logic        access, wr, known;

	assign events = {flags_i.forced, flags_i.writeback, flags_i.miss, flags_i.hit};
	assign access = apb_i.psel && apb_i.penable;
	assign wr     = access && apb_i.pwrite;

	always_ff @(posedge clock_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			lease_o <= RESET_LEASE;
			for (int i = 0; i < 4; i++) begin
				count_q[i] <= '0;
			end
		end else begin
			if (wr && apb_i.paddr == REG_LEASE) lease_o <= apb_i.pwdata[BW_LEASE-1:0];
			for (int i = 0; i < 4; i++) begin
				if (wr && apb_i.paddr == REG_HITS) begin
					count_q[i] <= '0;                                 // clears all four
				end else if (events[i] && count_q[i] != '1) begin
					count_q[i] <= count_q[i] + 1'b1;                  // saturate at max
				end
			end
		end
	end

	// read decode, prdata valid in access phase
	always_comb begin
		known        = 1'b1;
		apb_o.prdata = '0;
		case (apb_i.paddr)
			REG_LEASE:  apb_o.prdata = {{(32-BW_LEASE){1'b0}}, lease_o};
			REG_HITS:   apb_o.prdata = count_q[0];
			REG_MISSES: apb_o.prdata = count_q[1];
			REG_WBACKS: apb_o.prdata = count_q[2];
			REG_FORCED: apb_o.prdata = count_q[3];
			default:    known = 1'b0;
		endcase
		apb_o.pready  = 1'b1;                                  // no wait states
		apb_o.pslverr = access && !known;
	end

endmodule

// ==== design/lease_cache_controller.sv ====
`timescale 1ns/1ps

module lease_cache_controller import lease_cache_pkg::*; (
	input  logic                          clock_i,
	input  logic                          arst_n_i,

	input  logic                          core_req_i,
	input  core_req_t                     core_i,
	output logic                          core_done_o,
	output logic                          core_hit_o,
	output logic [31:0]                   core_rdata_o,

	input  logic                          cam_hit_i,
	input  logic [BW_CACHE_ADDR_PART-1:0] cam_addr_i,
	input  logic [BW_TAG-1:0]             cam_tag_i,
	input  logic                          cam_dirty_i,
	output logic                          cam_wren_o,
	output logic                          cam_dirty_set_o,
	output logic [BW_CACHE_ADDR_PART-1:0] cam_addr_o,   // also the lease tracker index

	input  logic [BW_CACHE_ADDR_PART-1:0] victim_i,
	input  logic                          forced_i,
	output logic                          renew_o,
	output logic                          step_o,

	input  logic [31:0]                   cache_q_i,
	output logic [BW_CACHE_ADDR_FULL-1:0] cache_addr_o,
	output logic                          cache_wren_o,
	output logic [31:0]                   cache_data_o,

	input  logic                          mem_ack_i,
	input  logic [31:0]                   mem_rdata_i,
	output logic                          mem_req_o,
	output mem_req_t                      mem_o,

	input  logic [BW_LEASE-1:0]           lease_i,      // default lease, zero means bypass
	output perf_flags_t                   flags_o
);

	typedef enum logic [2:0] {IDLE, LOOKUP, READ, WB, FILL, BYPASS, DONE} state_t;

	state_t                        state_q;
	logic [BW_CACHE_ADDR_PART-1:0] victim_q;     // block being replaced
	logic [BW_CACHE_ADDR_PART-1:0] blk;
	logic [BW_BLOCK-1:0]           cnt_q;        // word within wb or fill burst
	logic                          gap_q;        // hold off request for a cycle
	logic                          hit_q;
	logic                          bypass_q;
	logic [31:0]                   byp_data_q;
	logic [BW_TAG-1:0]             req_tag;
	logic [BW_BLOCK-1:0]           req_word;
	logic                          lookup_hit, lookup_miss;

	assign req_tag     = core_i.addr[BW_WORD_ADDR-1:BW_BLOCK];
	assign req_word    = core_i.addr[BW_BLOCK-1:0];
	assign lookup_hit  = state_q == LOOKUP && cam_hit_i;
	assign lookup_miss = state_q == LOOKUP && !cam_hit_i;

	// state and burst control
	// --------------------------------------------------
	always_ff @(posedge clock_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q  <= IDLE;
			victim_q <= '0;
			cnt_q    <= '0;
			gap_q    <= 1'b0;
			hit_q    <= 1'b0;
			bypass_q <= 1'b0;
		end else begin
			gap_q <= mem_ack_i;                                 // one idle cycle after each ack
			case (state_q)
				IDLE: if (core_req_i) state_q <= LOOKUP;
				LOOKUP: begin
					hit_q    <= cam_hit_i;
					bypass_q <= !cam_hit_i && lease_i == '0;
					victim_q <= victim_i;
					if (cam_hit_i) begin
						state_q <= DONE;                              // data read already issued
					end else if (lease_i == '0) begin
						state_q <= BYPASS;
					end else if (cam_dirty_i) begin
						state_q <= WB;
						gap_q   <= 1'b1;                              // let first word come out of ram
					end else begin
						state_q <= FILL;
					end
				end
				WB: if (mem_ack_i) begin
					cnt_q <= cnt_q + 1'b1;
					if (cnt_q == '1) state_q <= FILL;
				end
				FILL: if (mem_ack_i) begin
					cnt_q <= cnt_q + 1'b1;
					if (cnt_q == '1) state_q <= READ;
				end
				READ:    state_q <= DONE;
				BYPASS:  if (mem_ack_i) state_q <= DONE;
				DONE:    state_q <= IDLE;
				default: state_q <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clock_i) begin
		if (state_q == BYPASS && mem_ack_i) begin
			byp_data_q <= mem_rdata_i;                          // uncached load word
		end
	end

	// datapath and strobes
	// --------------------------------------------------
	always_comb begin
		if (state_q == LOOKUP) begin
			blk = cam_hit_i ? cam_addr_i : victim_i;            // victim for dirty check
		end else begin
			blk = victim_q;
		end
		cam_addr_o      = blk;
		cache_addr_o    = {blk, (state_q == WB || state_q == FILL) ? cnt_q : req_word};
		cam_wren_o      = state_q == FILL && mem_ack_i && cnt_q == '1; // last fill word
		cam_dirty_set_o = lookup_hit && core_i.rw;
		cache_wren_o    = (lookup_hit && core_i.rw) || (state_q == READ && core_i.rw) ||
		                  (state_q == FILL && mem_ack_i);
		cache_data_o    = (state_q == FILL) ? mem_rdata_i : core_i.wdata;
		renew_o         = lookup_hit || state_q == READ;
		step_o          = renew_o || (state_q == BYPASS && mem_ack_i);

		mem_req_o = (state_q == WB || state_q == FILL || state_q == BYPASS) && !gap_q;
		case (state_q)
			WB:      mem_o = '{we: 1'b1, addr: {cam_tag_i, cnt_q}, wdata: cache_q_i};
			FILL:    mem_o = '{we: 1'b0, addr: {req_tag, cnt_q}, wdata: 32'd0};
			default: mem_o = '{we: core_i.rw, addr: core_i.addr, wdata: core_i.wdata};
		endcase

		flags_o.hit       = lookup_hit;
		flags_o.miss      = lookup_miss;                       // bypass misses count too
		flags_o.writeback = state_q == WB && mem_ack_i;
		flags_o.forced    = lookup_miss && lease_i != '0 && forced_i;
	end

	assign core_done_o  = state_q == DONE;
	assign core_hit_o   = state_q == DONE && hit_q;
	assign core_rdata_o = bypass_q ? byp_data_q : cache_q_i;

	a_mem_stable: assert property (@(posedge clock_i) disable iff (!arst_n_i)
		mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_o));

endmodule

// ==== design/lease_cache_fa.sv ====
`timescale 1ns/1ps

module lease_cache_fa import lease_cache_pkg::*; (
	input  logic        clock_i,
	input  logic        arst_n_i,
	input  logic        core_req_i,
	input  core_req_t   core_i,
	output logic        core_done_o,
	output logic        core_hit_o,
	output logic [31:0] core_rdata_o,
	output logic        mem_req_o,
	output mem_req_t    mem_o,
	input  logic        mem_ack_i,
	input  logic [31:0] mem_rdata_i,
	input  apb_req_t    apb_i,
	output apb_rsp_t    apb_o
);

	logic [BW_TAG-1:0]               req_tag;
	logic                            cam_wren, cam_dirty_set, cam_hit, cam_dirty;
	logic [BW_CACHE_ADDR_PART-1:0]   add_ctrl2cam, add_cam2ctrl, victim;
	logic [BW_TAG-1:0]               cam_tag;
	logic [CACHE_BLOCK_CAPACITY-1:0] valid;
	logic                            forced, renew, step;
	logic [BW_CACHE_ADDR_FULL-1:0]   cache_addr;
	logic                            cache_wren;
	logic [31:0]                     cache_wdata, cache_q;
	perf_flags_t                     flags;
	logic [BW_LEASE-1:0]             lease;

	assign req_tag = core_i.addr[BW_WORD_ADDR-1:BW_BLOCK];  // [tag|word]

	// --------------------------------------------------
	tag_memory_fa u_tag (
		.clock_i, .arst_n_i,
		.wren_i      (cam_wren),
		.dirty_set_i (cam_dirty_set),
		.tag_i       (req_tag),
		.add_i       (add_ctrl2cam),
		.dirty_i     (core_i.rw),                             // store fills allocate dirty
		.hit_o       (cam_hit),
		.add_o       (add_cam2ctrl),
		.tag_o       (cam_tag),
		.dirty_o     (cam_dirty),
		.valid_o     (valid)
	);

	lease_tracker u_lease (
		.clock_i, .arst_n_i,
		.renew_i (renew), .step_i (step), .index_i (add_ctrl2cam),
		.lease_i (lease), .valid_i (valid),
		.victim_o (victim), .forced_o (forced)
	);

	cache_data_mem u_data (
		.clock_i, .wren_i (cache_wren), .addr_i (cache_addr), .data_i (cache_wdata), .q_o (cache_q)
	);

	lease_cache_controller u_ctrl (
		.clock_i, .arst_n_i,
		.core_req_i, .core_i, .core_done_o, .core_hit_o, .core_rdata_o,
		.cam_hit_i (cam_hit), .cam_addr_i (add_cam2ctrl), .cam_tag_i (cam_tag),
		.cam_dirty_i (cam_dirty), .cam_wren_o (cam_wren), .cam_dirty_set_o (cam_dirty_set),
		.cam_addr_o (add_ctrl2cam),
		.victim_i (victim), .forced_i (forced), .renew_o (renew), .step_o (step),
		.cache_q_i (cache_q), .cache_addr_o (cache_addr), .cache_wren_o (cache_wren),
		.cache_data_o (cache_wdata),
		.mem_ack_i, .mem_rdata_i, .mem_req_o, .mem_o,
		.lease_i (lease), .flags_o (flags)
	);

	cache_perf_regs u_perf (
		.clock_i, .arst_n_i, .flags_i (flags), .apb_i, .apb_o, .lease_o (lease)
	);

endmodule

// ==== design/lease_cache_pkg.sv ====
package lease_cache_pkg;

	// address layout  [tag|word]
	// --------------------------------------------------
	localparam int BW_WORD_ADDR         = 16;                     // core and memory word address
	localparam int BW_BLOCK             = 2;                      // 4 words per block
	localparam int BW_TAG               = BW_WORD_ADDR - BW_BLOCK;
	localparam int CACHE_BLOCK_CAPACITY = 8;
	localparam int BW_CACHE_ADDR_PART   = 3;                      // block index
	localparam int BW_CACHE_ADDR_FULL   = BW_CACHE_ADDR_PART + BW_BLOCK; // [block|word]
	localparam int BW_LEASE             = 8;
	localparam int BW_APB_ADDR          = 8;

	localparam logic [BW_LEASE-1:0] RESET_LEASE = 8'd4;       // default lease out of reset

	// apb register map
	// --------------------------------------------------
	localparam logic [BW_APB_ADDR-1:0] REG_LEASE  = 8'h00;    // rw, low 8 bits
	localparam logic [BW_APB_ADDR-1:0] REG_HITS   = 8'h04;    // write clears all counters
	localparam logic [BW_APB_ADDR-1:0] REG_MISSES = 8'h08;
	localparam logic [BW_APB_ADDR-1:0] REG_WBACKS = 8'h0C;
	localparam logic [BW_APB_ADDR-1:0] REG_FORCED = 8'h10;

	// port bundles
	// --------------------------------------------------
	typedef struct packed {
		logic                    rw;                            // 1: store, 0: load
		logic [BW_WORD_ADDR-1:0] addr;
		logic [31:0]             wdata;
	} core_req_t;

	typedef struct packed {
		logic                    we;                            // 1: write word to memory
		logic [BW_WORD_ADDR-1:0] addr;
		logic [31:0]             wdata;
	} mem_req_t;

	typedef struct packed {
		logic hit;                                               // single cycle strobes
		logic miss;
		logic writeback;                                         // one per word written back
		logic forced;                                            // victim had lease left
	} perf_flags_t;

	typedef struct packed {
		logic                   psel;
		logic                   penable;
		logic                   pwrite;
		logic [BW_APB_ADDR-1:0] paddr;
		logic [31:0]            pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

endpackage

// ==== design/lease_tracker.sv ====
`timescale 1ns/1ps

module lease_tracker import lease_cache_pkg::*; (
	input  logic                            clock_i,
	input  logic                            arst_n_i,
	input  logic                            renew_i,   // load index_i with lease_i
	input  logic                            step_i,    // age the other blocks
	input  logic [BW_CACHE_ADDR_PART-1:0]   index_i,
	input  logic [BW_LEASE-1:0]             lease_i,   // default lease
	input  logic [CACHE_BLOCK_CAPACITY-1:0] valid_i,   // from the tag cam
	output logic [BW_CACHE_ADDR_PART-1:0]   victim_o,
	output logic                            forced_o   // victim still had lease left
);

	logic [BW_LEASE-1:0]           lease_q [CACHE_BLOCK_CAPACITY];
	logic                          inv_found, exp_found;
	logic [BW_CACHE_ADDR_PART-1:0] inv_idx, exp_idx, min_idx;
	logic [BW_LEASE-1:0]           min_val;

	// step alone (bypass access) ages every block, with renew it spares index_i
	always_ff @(posedge clock_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < CACHE_BLOCK_CAPACITY; i++) begin
				lease_q[i] <= '0;
			end
		end else begin
			for (int i = 0; i < CACHE_BLOCK_CAPACITY; i++) begin
				if (renew_i && index_i == BW_CACHE_ADDR_PART'(i)) begin
					lease_q[i] <= lease_i;
				end else if (step_i && lease_q[i] != '0) begin
					lease_q[i] <= lease_q[i] - 1'b1;
				end
			end
		end
	end

	// victim order: invalid, then expired, then smallest lease
	always_comb begin
		inv_found = 1'b0;
		exp_found = 1'b0;
		inv_idx   = '0;
		exp_idx   = '0;
		min_idx   = '0;
		min_val   = '1;
		for (int i = 0; i < CACHE_BLOCK_CAPACITY; i++) begin
			if (!valid_i[i] && !inv_found) begin
				inv_found = 1'b1;
				inv_idx   = BW_CACHE_ADDR_PART'(i);
			end
			if (valid_i[i] && lease_q[i] == '0 && !exp_found) begin
				exp_found = 1'b1;
				exp_idx   = BW_CACHE_ADDR_PART'(i);
			end
			if (lease_q[i] < min_val) begin                   // strict, ties keep lower index
				min_val = lease_q[i];
				min_idx = BW_CACHE_ADDR_PART'(i);
			end
		end
	end

	assign victim_o = inv_found ? inv_idx : (exp_found ? exp_idx : min_idx);
	assign forced_o = !inv_found && !exp_found;

	// cam entry is written before the block is renewed
	a_renew_valid: assert property (@(posedge clock_i) disable iff (!arst_n_i)
		renew_i |-> valid_i[index_i]);

endmodule

// ==== design/tag_memory_fa.sv ====
`timescale 1ns/1ps

module tag_memory_fa import lease_cache_pkg::*; (
	input  logic                            clock_i,
	input  logic                            arst_n_i,
	input  logic                            wren_i,       // write new entry at add_i
	input  logic                            dirty_set_i,  // mark entry at add_i dirty
	input  logic [BW_TAG-1:0]               tag_i,        // lookup and new tag
	input  logic [BW_CACHE_ADDR_PART-1:0]   add_i,        // entry for write and readback
	input  logic                            dirty_i,      // dirty bit of a new entry
	output logic                            hit_o,
	output logic [BW_CACHE_ADDR_PART-1:0]   add_o,        // matching entry
	output logic [BW_TAG-1:0]               tag_o,        // tag of entry add_i
	output logic                            dirty_o,      // dirty bit of entry add_i
	output logic [CACHE_BLOCK_CAPACITY-1:0] valid_o
);

	logic [BW_TAG-1:0]               tag_q [CACHE_BLOCK_CAPACITY];
	logic [CACHE_BLOCK_CAPACITY-1:0] valid_q;
	logic [CACHE_BLOCK_CAPACITY-1:0] dirty_q;
	logic                            dup;                 // two valid entries hold one tag

	always_ff @(posedge clock_i) begin
		if (wren_i) begin
			tag_q[add_i] <= tag_i;
		end
	end

	always_ff @(posedge clock_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_q <= '0;                                    // all blocks invalid
			dirty_q <= '0;
		end else if (wren_i) begin
			valid_q[add_i] <= 1'b1;
			dirty_q[add_i] <= dirty_i;
		end else if (dirty_set_i) begin
			dirty_q[add_i] <= 1'b1;                           // store hit
		end
	end

	// parallel match, lowest entry wins
	always_comb begin
		hit_o = 1'b0;
		add_o = '0;
		for (int i = 0; i < CACHE_BLOCK_CAPACITY; i++) begin
			if (valid_q[i] && tag_q[i] == tag_i && !hit_o) begin
				hit_o = 1'b1;
				add_o = BW_CACHE_ADDR_PART'(i);
			end
		end
	end

	always_comb begin
		dup = 1'b0;
		for (int i = 0; i < CACHE_BLOCK_CAPACITY; i++) begin
			for (int j = i + 1; j < CACHE_BLOCK_CAPACITY; j++) begin
				if (valid_q[i] && valid_q[j] && tag_q[i] == tag_q[j]) begin
					dup = 1'b1;
				end
			end
		end
	end

	assign tag_o   = tag_q[add_i];                          // writeback address source
	assign dirty_o = dirty_q[add_i];                        // invalid entries never dirty
	assign valid_o = valid_q;

	a_unique_tags: assert property (@(posedge clock_i) disable iff (!arst_n_i) !dup);

endmodule

// ==== project.f ====
design/lease_cache_pkg.sv
design/tag_memory_fa.sv
design/lease_tracker.sv
design/cache_data_mem.sv
design/lease_cache_controller.sv
design/cache_perf_regs.sv
design/lease_cache_fa.sv
bench/tb_clock_gen.sv
bench/backing_mem_model.sv
bench/lease_cache_tb.sv
